//--- src/cpu_pkg.sv
// shared widths, opcode and funct codes, ALU op enum, control struct and load struct
package cpu_pkg;

    // data path and address width
    localparam int xlen = 32;

    // instruction memory geometry
    localparam int imem_words = 256;
    localparam int imem_aw    = 8;

    // major opcodes
    localparam logic [6 : 0] op_r      = 7'b0110011;
    localparam logic [6 : 0] op_i      = 7'b0010011;
    localparam logic [6 : 0] op_lui    = 7'b0110111;
    localparam logic [6 : 0] op_branch = 7'b1100011;

    // funct3 codes for arithmetic and logic
    localparam logic [2 : 0] f3_add = 3'b000;
    localparam logic [2 : 0] f3_sll = 3'b001;
    localparam logic [2 : 0] f3_srl = 3'b101;
    localparam logic [2 : 0] f3_or  = 3'b110;
    localparam logic [2 : 0] f3_and = 3'b111;

    // funct3 codes for branches
    localparam logic [2 : 0] f3_beq = 3'b000;
    localparam logic [2 : 0] f3_bne = 3'b001;

    // funct7 codes, sub differs from add only here
    localparam logic [6 : 0] f7_base = 7'b0000000;
    localparam logic [6 : 0] f7_sub  = 7'b0100000;

    typedef enum logic [2 : 0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_sll,
        alu_srl,
        alu_passb
    } alu_op_t;

    // immediate format
    typedef enum logic [1 : 0] {
        imm_i,
        imm_u,
        imm_b
    } imm_kind_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       src_b_reg;
        logic       reg_we;
        logic       branch;
        logic       branch_ne;
        imm_kind_t  imm_kind;
    } ctrl_t;

    // host load port of the instruction memory
    typedef struct packed {
        logic                   en;
        logic [imem_aw-1 : 0]   addr;
        logic [xlen-1 : 0]      data;
    } imem_load_t;

endpackage : cpu_pkg

//--- src/cpu_register_file.sv
// register file with two read ports, one write port and a debug read port
`timescale 1ns/10ps

module cpu_register_file
(
    input   logic                           clk,
    input   logic                           arst_n,
    input   logic   [4 : 0]                 ra1,
    input   logic   [4 : 0]                 ra2,
    input   logic   [4 : 0]                 wa,
    input   logic   [4 : 0]                 rd_dbg_addr,
    input   logic   [cpu_pkg::xlen-1 : 0]   wd,
    input   logic                           we,
    output  logic   [cpu_pkg::xlen-1 : 0]   rd1,
    output  logic   [cpu_pkg::xlen-1 : 0]   rd2,
    output  logic   [cpu_pkg::xlen-1 : 0]   rd_dbg
);

    // x0 has no storage
    logic   [cpu_pkg::xlen-1 : 0]   regs [31 : 1];

    // x0 is hardwired to zero on every read port
    function automatic logic [cpu_pkg::xlen-1 : 0] read_reg(input logic [4 : 0] a);
        read_reg = (a == 5'd0) ? '0 : regs[a];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1    = read_reg(ra1);
    assign rd2    = read_reg(ra2);
    assign rd_dbg = read_reg(rd_dbg_addr);

endmodule : cpu_register_file

//--- src/cpu_alu.sv
// combinational ALU for add, sub, and, or, shifts and pass-b
`timescale 1ns/10ps

module cpu_alu
(
    input   logic   [cpu_pkg::xlen-1 : 0]   a,
    input   logic   [cpu_pkg::xlen-1 : 0]   b,
    input   cpu_pkg::alu_op_t               op,
    output  logic   [cpu_pkg::xlen-1 : 0]   y
);

    logic   [4 : 0] shamt;

    // low five bits serve both register shifts and shamt immediates
    assign shamt = b[4 : 0];

    always_comb begin
        case (op)
            cpu_pkg::alu_add: begin
                y = a + b;
            end
            cpu_pkg::alu_sub: begin
                y = a - b;
            end
            cpu_pkg::alu_and: begin
                y = a & b;
            end
            cpu_pkg::alu_or: begin
                y = a | b;
            end
            cpu_pkg::alu_sll: begin
                y = a << shamt;
            end
            cpu_pkg::alu_srl: begin
                y = a >> shamt;
            end
            // lui result arrives already shifted
            cpu_pkg::alu_passb: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule : cpu_alu

//--- src/cpu_control_unit.sv
// instruction decoder producing the control struct and the sign-extended immediate
`timescale 1ns/10ps

module cpu_control_unit
(
    input   logic   [cpu_pkg::xlen-1 : 0]   instr,
    output  cpu_pkg::ctrl_t                 ctrl,
    output  logic   [cpu_pkg::xlen-1 : 0]   imm
);

    logic   [6 : 0] opcode;
    logic   [2 : 0] funct3;
    logic   [6 : 0] funct7;

    assign opcode = instr[6 : 0];
    assign funct3 = instr[14 : 12];
    assign funct7 = instr[31 : 25];

    always_comb begin
        // anything not matched below stays a no-op
        ctrl.alu_op    = cpu_pkg::alu_add;
        ctrl.src_b_reg = 1'b0;
        ctrl.reg_we    = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.branch_ne = 1'b0;
        ctrl.imm_kind  = cpu_pkg::imm_i;
        case (opcode)
            cpu_pkg::op_r: begin
                ctrl.src_b_reg = 1'b1;
                ctrl.reg_we    = 1'b1;
                case ({funct7, funct3})
                    {cpu_pkg::f7_base, cpu_pkg::f3_add}: ctrl.alu_op = cpu_pkg::alu_add;
                    {cpu_pkg::f7_sub,  cpu_pkg::f3_add}: ctrl.alu_op = cpu_pkg::alu_sub;
                    {cpu_pkg::f7_base, cpu_pkg::f3_and}: ctrl.alu_op = cpu_pkg::alu_and;
                    {cpu_pkg::f7_base, cpu_pkg::f3_or}:  ctrl.alu_op = cpu_pkg::alu_or;
                    {cpu_pkg::f7_base, cpu_pkg::f3_sll}: ctrl.alu_op = cpu_pkg::alu_sll;
                    {cpu_pkg::f7_base, cpu_pkg::f3_srl}: ctrl.alu_op = cpu_pkg::alu_srl;
                    default: ctrl.reg_we = 1'b0;
                endcase
            end
            cpu_pkg::op_i: begin
                ctrl.reg_we = 1'b1;
                if (funct3 == cpu_pkg::f3_add) begin
                    ctrl.alu_op = cpu_pkg::alu_add;
                end else if (funct3 == cpu_pkg::f3_or) begin
                    ctrl.alu_op = cpu_pkg::alu_or;
                end else if (funct3 == cpu_pkg::f3_sll && funct7 == cpu_pkg::f7_base) begin
                    // shamt sits in the low bits of the i-immediate
                    ctrl.alu_op = cpu_pkg::alu_sll;
                end else begin
                    ctrl.reg_we = 1'b0;
                end
            end
            cpu_pkg::op_lui: begin
                ctrl.alu_op   = cpu_pkg::alu_passb;
                ctrl.reg_we   = 1'b1;
                ctrl.imm_kind = cpu_pkg::imm_u;
            end
            cpu_pkg::op_branch: begin
                ctrl.imm_kind = cpu_pkg::imm_b;
                if (funct3 == cpu_pkg::f3_beq || funct3 == cpu_pkg::f3_bne) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = (funct3 == cpu_pkg::f3_bne);
                end
            end
            default: begin
                ctrl.reg_we = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (ctrl.imm_kind)
            cpu_pkg::imm_i: imm = {{20{instr[31]}}, instr[31 : 20]};
            cpu_pkg::imm_u: imm = {instr[31 : 12], 12'b0};
            // branch offset comes out already in bytes
            cpu_pkg::imm_b: imm = {{19{instr[31]}}, instr[31], instr[7],
                                   instr[30 : 25], instr[11 : 8], 1'b0};
            default:        imm = '0;
        endcase
    end

endmodule : cpu_control_unit

//--- src/cpu_core.sv
// single-cycle core: program counter, operand and next-pc selection, branch compare
`timescale 1ns/10ps

module cpu_core
(
    input   logic                           clk,
    input   logic                           arst_n,
    input   logic                           cpu_en,
    input   logic   [cpu_pkg::xlen-1 : 0]   instr,
    input   logic   [4 : 0]                 reg_addr,
    output  logic   [cpu_pkg::xlen-1 : 0]   pc,
    output  logic   [cpu_pkg::xlen-1 : 0]   reg_data
);

    cpu_pkg::ctrl_t                 ctrl;
    logic   [cpu_pkg::xlen-1 : 0]   imm;
    logic   [cpu_pkg::xlen-1 : 0]   rd1;
    logic   [cpu_pkg::xlen-1 : 0]   rd2;
    logic   [cpu_pkg::xlen-1 : 0]   src_b;
    logic   [cpu_pkg::xlen-1 : 0]   result;
    logic   [cpu_pkg::xlen-1 : 0]   pc_next;
    logic                           br_taken;

    // program counter, frozen while the core is disabled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (cpu_en) begin
            pc <= pc_next;
        end
    end

    assign src_b = ctrl.src_b_reg ? rd2 : imm;

    // equality result flipped for bne
    assign br_taken = ctrl.branch && ((rd1 == rd2) != ctrl.branch_ne);

    assign pc_next = br_taken ? (pc + imm) : (pc + 32'd4);

    cpu_control_unit u_control_unit
    (
        .instr          ( instr                     ),
        .ctrl           ( ctrl                      ),
        .imm            ( imm                       )
    );

    cpu_register_file u_register_file
    (
        .clk            ( clk                       ),
        .arst_n         ( arst_n                    ),
        .ra1            ( instr[19 : 15]            ),
        .ra2            ( instr[24 : 20]            ),
        .wa             ( instr[11 : 7]             ),
        .rd_dbg_addr    ( reg_addr                  ),
        .wd             ( result                    ),
        .we             ( ctrl.reg_we && cpu_en     ),
        .rd1            ( rd1                       ),
        .rd2            ( rd2                       ),
        .rd_dbg         ( reg_data                  )
    );

    cpu_alu u_alu
    (
        .a              ( rd1                       ),
        .b              ( src_b                     ),
        .op             ( ctrl.alu_op               ),
        .y              ( result                    )
    );

endmodule : cpu_core

//--- src/cpu_instr_mem.sv
// instruction memory with asynchronous read and a synchronous host load port
`timescale 1ns/10ps

module cpu_instr_mem
(
    input   logic                               clk,
    input   cpu_pkg::imem_load_t                load,
    input   logic   [cpu_pkg::imem_aw-1 : 0]    addr,
    output  logic   [cpu_pkg::xlen-1 : 0]       rdata
);

    logic   [cpu_pkg::xlen-1 : 0]   mem [cpu_pkg::imem_words];

    // host writes one word per edge
    always_ff @(posedge clk) begin
        if (load.en) begin
            mem[load.addr] <= load.data;
        end
    end

    // word-addressed read
    assign rdata = mem[addr];

endmodule : cpu_instr_mem

//--- src/cpu_top.sv
// top level joining the core and the instruction memory
`timescale 1ns/10ps

module cpu_top
(
    input   logic                           clk,
    input   logic                           arst_n,
    input   logic                           cpu_en,
    input   cpu_pkg::imem_load_t            imem_load,
    input   logic   [4 : 0]                 reg_addr,
    output  logic   [cpu_pkg::xlen-1 : 0]   reg_data,
    output  logic   [cpu_pkg::xlen-1 : 0]   pc
);

    logic   [cpu_pkg::xlen-1 : 0]   instr;

    cpu_core u_core
    (
        .clk            ( clk                               ),
        .arst_n         ( arst_n                            ),
        .cpu_en         ( cpu_en                            ),
        .instr          ( instr                             ),
        .reg_addr       ( reg_addr                          ),
        .pc             ( pc                                ),
        .reg_data       ( reg_data                          )
    );

    // byte pc to word address
    cpu_instr_mem u_instr_mem
    (
        .clk            ( clk                               ),
        .load           ( imem_load                         ),
        .addr           ( pc[cpu_pkg::imem_aw+1 : 2]        ),
        .rdata          ( instr                             )
    );

endmodule : cpu_top

//--- test/cpu_core_checker.sv
// concurrent assertions on the core's pc and debug read port, bound to cpu_core
`timescale 1ns/10ps

module cpu_core_checker
(
    input   logic           clk,
    input   logic           arst_n,
    input   logic           cpu_en,
    input   logic   [31 : 0] pc,
    input   logic   [4 : 0]  reg_addr,
    input   logic   [31 : 0] reg_data
);

    // instructions are word sized
    assert property (@(posedge clk) disable iff (!arst_n) pc[1 : 0] == 2'b00)
        else $error("pc is not word aligned");

    assert property (@(posedge clk) disable iff (!arst_n) !cpu_en |=> $stable(pc))
        else $error("pc moved while the core was disabled");

    assert property (@(posedge clk) disable iff (!arst_n) reg_addr == 5'd0 |-> reg_data == '0)
        else $error("x0 read back nonzero");

    // first edge after reset release
    assert property (@(posedge clk) $rose(arst_n) |-> pc == '0)
        else $error("pc not zero after reset release");

endmodule : cpu_core_checker

bind cpu_core cpu_core_checker u_checker
(
    .clk        ( clk       ),
    .arst_n     ( arst_n    ),
    .cpu_en     ( cpu_en    ),
    .pc         ( pc        ),
    .reg_addr   ( reg_addr  ),
    .reg_data   ( reg_data  )
);

//--- test/cpu_tb.sv
// testbench for cpu_top: clock, reset, LFSR, encoders, program runner and directed tests
`timescale 1ns/10ps

module cpu_tb;

    localparam int max_cycles = 2000;

    logic                   clk;
    logic                   arst_n;
    logic                   cpu_en;
    cpu_pkg::imem_load_t    imem_load;
    logic   [4 : 0]         reg_addr;
    logic   [31 : 0]        reg_data;
    logic   [31 : 0]        pc;

    logic   [31 : 0]        prog [$];
    logic   [31 : 0]        trap_addr;
    logic   [31 : 0]        lfsr;
    int                     errors;
    int                     cycles;

    cpu_top u_dut
    (
        .clk        ( clk       ),
        .arst_n     ( arst_n    ),
        .cpu_en     ( cpu_en    ),
        .imem_load  ( imem_load ),
        .reg_addr   ( reg_addr  ),
        .reg_data   ( reg_data  ),
        .pc         ( pc        )
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31 : 0] rand_bits(input int n);
        logic [31 : 0] v;
        logic          fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30 : 0], fb};
            v    = {v[30 : 0], fb};
        end
        return v;
    endfunction

    function automatic logic [31 : 0] sext12(input logic [11 : 0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31 : 0] enc_r(input logic [6 : 0] f7, input logic [4 : 0] rs2,
                                            input logic [4 : 0] rs1, input logic [2 : 0] f3,
                                            input logic [4 : 0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::op_r};
    endfunction

    function automatic logic [31 : 0] enc_i(input logic [11 : 0] imm, input logic [4 : 0] rs1,
                                            input logic [2 : 0] f3, input logic [4 : 0] rd);
        return {imm, rs1, f3, rd, cpu_pkg::op_i};
    endfunction

    function automatic logic [31 : 0] enc_lui(input logic [19 : 0] imm, input logic [4 : 0] rd);
        return {imm, rd, cpu_pkg::op_lui};
    endfunction

    // offset in bytes, bit 0 dropped
    function automatic logic [31 : 0] enc_b(input logic [12 : 0] off, input logic [4 : 0] rs2,
                                            input logic [4 : 0] rs1, input logic [2 : 0] f3);
        return {off[12], off[10 : 5], rs2, rs1, f3, off[4 : 1], off[11], cpu_pkg::op_branch};
    endfunction

    // lui takes the carry that the sign-extended addi will subtract
    task automatic push_const(input logic [4 : 0] rd, input logic [31 : 0] v);
        logic [19 : 0] up;
        up = v[31 : 12] + {19'b0, v[11]};
        prog.push_back(enc_lui(up, rd));
        prog.push_back(enc_i(v[11 : 0], rd, cpu_pkg::f3_add, rd));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #10 arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #10 arst_n = 1'b1;
    endtask

    // reset, then load the queued program followed by the trap
    task automatic load_program();
        cpu_en = 1'b0;
        apply_reset();
        prog.push_back(enc_b(13'd0, 5'd0, 5'd0, cpu_pkg::f3_beq));
        trap_addr = 32'(4 * (prog.size() - 1));
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #10;
            imem_load.en   = 1'b1;
            imem_load.addr = 8'(i);
            imem_load.data = prog[i];
        end
        @(posedge clk);
        #10 imem_load.en = 1'b0;
        prog.delete();
    endtask

    task automatic run_to_trap();
        @(posedge clk);
        #10 cpu_en = 1'b1;
        do begin
            @(posedge clk);
            #10;
        end while (pc != trap_addr);
        // trap keeps spinning a few more cycles
        repeat (2) @(posedge clk);
        #10 cpu_en = 1'b0;
    endtask

    task automatic read_reg(input logic [4 : 0] idx, output logic [31 : 0] v);
        @(posedge clk);
        #10 reg_addr = idx;
        #5 v = reg_data;
    endtask

    task automatic check_reg(input logic [4 : 0] idx, input logic [31 : 0] exp);
        logic [31 : 0] got;
        read_reg(idx, got);
        assert (got == exp) else begin
            $display("FAILED reg_data x%0d got 0x%08h expected 0x%08h", idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [31 : 0] exp);
        assert (pc == exp) else begin
            $display("FAILED pc got 0x%08h expected 0x%08h", pc, exp);
            errors++;
        end
    endtask

    task automatic test_reset();
        apply_reset();
        check_pc(32'd0);
        for (int i = 0; i < 32; i++) begin
            check_reg(5'(i), 32'd0);
        end
    endtask

    task automatic test_reg_ops();
        logic [31 : 0] a;
        logic [31 : 0] b;
        a = rand_bits(32);
        b = rand_bits(32);
        push_const(5'd1, a);
        push_const(5'd2, b);
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd2, 5'd1, cpu_pkg::f3_add, 5'd3));
        prog.push_back(enc_r(cpu_pkg::f7_sub, 5'd2, 5'd1, cpu_pkg::f3_add, 5'd4));
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd2, 5'd1, cpu_pkg::f3_and, 5'd5));
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd2, 5'd1, cpu_pkg::f3_or, 5'd6));
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd2, 5'd1, cpu_pkg::f3_sll, 5'd7));
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd2, 5'd1, cpu_pkg::f3_srl, 5'd8));
        load_program();
        run_to_trap();
        check_reg(5'd1, a);
        check_reg(5'd2, b);
        check_reg(5'd3, a + b);
        check_reg(5'd4, a - b);
        check_reg(5'd5, a & b);
        check_reg(5'd6, a | b);
        check_reg(5'd7, a << b[4 : 0]);
        check_reg(5'd8, a >> b[4 : 0]);
    endtask

    task automatic test_imm_ops();
        logic [31 : 0] a;
        logic [11 : 0] neg;
        logic [11 : 0] orv;
        logic [4 : 0]  sh;
        logic [19 : 0] up;
        a   = rand_bits(32);
        neg = {1'b1, 11'(rand_bits(11))};
        orv = 12'(rand_bits(12));
        sh  = 5'(rand_bits(5));
        up  = 20'(rand_bits(20));
        push_const(5'd1, a);
        prog.push_back(enc_i(neg, 5'd1, cpu_pkg::f3_add, 5'd2));
        prog.push_back(enc_i(orv, 5'd1, cpu_pkg::f3_or, 5'd3));
        prog.push_back(enc_i({7'b0, sh}, 5'd1, cpu_pkg::f3_sll, 5'd4));
        prog.push_back(enc_lui(up, 5'd5));
        load_program();
        run_to_trap();
        check_reg(5'd2, a + sext12(neg));
        check_reg(5'd3, a | sext12(orv));
        check_reg(5'd4, a << sh);
        check_reg(5'd5, {up, 12'b0});
    endtask

    task automatic test_branches();
        logic [31 : 0] n;
        n = {28'b0, 4'(rand_bits(4))};
        if (n == 0) begin
            n = 1;
        end
        prog.push_back(enc_i(12'd5, 5'd0, cpu_pkg::f3_add, 5'd1));
        prog.push_back(enc_i(12'd5, 5'd0, cpu_pkg::f3_add, 5'd2));
        prog.push_back(enc_i(12'd7, 5'd0, cpu_pkg::f3_add, 5'd3));
        // each branch skips the addi after it when taken
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, cpu_pkg::f3_beq));
        prog.push_back(enc_i(12'd1, 5'd0, cpu_pkg::f3_add, 5'd10));
        prog.push_back(enc_b(13'd8, 5'd3, 5'd1, cpu_pkg::f3_beq));
        prog.push_back(enc_i(12'd1, 5'd0, cpu_pkg::f3_add, 5'd11));
        prog.push_back(enc_b(13'd8, 5'd3, 5'd1, cpu_pkg::f3_bne));
        prog.push_back(enc_i(12'd1, 5'd0, cpu_pkg::f3_add, 5'd12));
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, cpu_pkg::f3_bne));
        prog.push_back(enc_i(12'd1, 5'd0, cpu_pkg::f3_add, 5'd13));
        // countdown loop
        prog.push_back(enc_i(n[11 : 0], 5'd0, cpu_pkg::f3_add, 5'd5));
        prog.push_back(enc_i(12'd0, 5'd0, cpu_pkg::f3_add, 5'd6));
        prog.push_back(enc_i(12'd1, 5'd6, cpu_pkg::f3_add, 5'd6));
        prog.push_back(enc_i(12'hfff, 5'd5, cpu_pkg::f3_add, 5'd5));
        prog.push_back(enc_b(-13'sd8, 5'd0, 5'd5, cpu_pkg::f3_bne));
        load_program();
        run_to_trap();
        check_pc(trap_addr);
        // beq 5,5 and bne 5,7 are taken, beq 5,7 and bne 5,5 fall through
        check_reg(5'd10, 32'd0);
        check_reg(5'd11, 32'd1);
        check_reg(5'd12, 32'd0);
        check_reg(5'd13, 32'd1);
        check_reg(5'd5, 32'd0);
        check_reg(5'd6, n);
    endtask

    task automatic push_enable_program();
        prog.push_back(enc_i(12'd100, 5'd0, cpu_pkg::f3_add, 5'd1));
        prog.push_back(enc_i(12'd123, 5'd0, cpu_pkg::f3_add, 5'd0));
        prog.push_back(enc_i(12'hffd, 5'd1, cpu_pkg::f3_add, 5'd2));
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd2, 5'd1, cpu_pkg::f3_add, 5'd3));
        prog.push_back(enc_r(cpu_pkg::f7_base, 5'd1, 5'd3, cpu_pkg::f3_or, 5'd4));
        prog.push_back(enc_i(12'd2, 5'd4, cpu_pkg::f3_sll, 5'd5));
    endtask

    task automatic check_enable_result();
        check_reg(5'd0, 32'd0);
        check_reg(5'd1, 32'd100);
        check_reg(5'd2, 32'd97);
        check_reg(5'd3, 32'd197);
        check_reg(5'd4, 32'd197 | 32'd100);
        check_reg(5'd5, (32'd197 | 32'd100) << 2);
    endtask

    task automatic test_enable_x0();
        logic [31 : 0] pc_hold;
        logic [31 : 0] x3_hold;
        logic [31 : 0] x3_now;
        push_enable_program();
        load_program();
        run_to_trap();
        check_enable_result();
        // same program, paused after three instructions
        push_enable_program();
        load_program();
        @(posedge clk);
        #10 cpu_en = 1'b1;
        repeat (3) @(posedge clk);
        #10 cpu_en = 1'b0;
        pc_hold = pc;
        // x3 is the target of the instruction waiting at pc
        read_reg(5'd3, x3_hold);
        repeat (5) @(posedge clk);
        #10;
        check_pc(pc_hold);
        read_reg(5'd3, x3_now);
        assert (x3_now == x3_hold) else begin
            $display("FAILED reg_data x3 got 0x%08h expected 0x%08h", x3_now, x3_hold);
            errors++;
        end
        run_to_trap();
        check_pc(trap_addr);
        check_enable_result();
    endtask

    initial begin
        clk            = 1'b0;
        arst_n         = 1'b0;
        cpu_en         = 1'b0;
        imem_load.en   = 1'b0;
        imem_load.addr = '0;
        imem_load.data = '0;
        reg_addr       = '0;
        lfsr           = 32'h1c13a0df;
        errors         = 0;
        cycles         = 0;
        test_reset();
        test_reg_ops();
        test_imm_ops();
        test_branches();
        test_enable_x0();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : cpu_tb

//--- files.f
src/cpu_pkg.sv
src/cpu_register_file.sv
src/cpu_alu.sv
src/cpu_control_unit.sv
src/cpu_core.sv
src/cpu_instr_mem.sv
src/cpu_top.sv
test/cpu_core_checker.sv
test/cpu_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cpu_tb
FILELIST = files.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
